//--- sim.f
hdl/wb_pkg.sv
hdl/wb_load_unit.sv
hdl/wb_csr_access.sv
hdl/wb_flow_ctrl.sv
hdl/wb_gpr_commit.sv
hdl/wb_stage_top.sv
sim/tb_wb_stage.sv

//--- sim/tb_wb_stage.sv
/*
 * Testbench for the writeback stage.
 * Feeds ALU, load, store, jump, trap, MRET and CSR instructions through
 * the upstream handshake. It models fetch acknowledge with a random delay
 * and a fixed CSR file, and checks every cycle against a model PC.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_wb_stage import wb_pkg::*; ();

    localparam wb_word_t pc_start   = 32'h8000_0000;
    localparam wb_word_t mtvec_val  = 32'h8000_0100;
    localparam wb_word_t mepc_val   = 32'h8000_2468;
    localparam int       n_tests    = 40;           // Rough instruction count
    localparam int       max_stall  = 5;            // Ack delay plus request cycle
    localparam int       max_cycles = 2 * n_tests * max_stall;

    logic         g_clk;
    logic         g_resetn;
    wb_instr_t    instr;
    logic         instr_valid;
    logic         busy;
    wb_dmem_rsp_t dmem_rsp;
    wb_csr_req_t  csr_req;
    wb_word_t     csr_rdata;
    logic         csr_error;                        // CSR file rejects this access
    logic         csr_fault;
    wb_gpr_wr_t   gpr_wr;
    logic         cf_req;
    wb_word_t     cf_target;
    logic         cf_ack;
    logic         exec_mret;
    wb_trap_t     trap;
    wb_trace_t    trace;

    // Expected response of the instruction in the stage
    logic       exp_wen;
    logic [4:0] exp_rd;
    wb_word_t   exp_wdata;
    logic       exp_cf;                             // Flow change expected
    wb_word_t   exp_target;
    logic       exp_trap;
    logic [5:0] exp_cause;
    wb_word_t   exp_mtval;
    logic       exp_mret;
    logic       exp_csr;

    wb_word_t    model_pc;
    logic [31:0] lcg_state;
    int          cycles;
    int          checks;
    int          value_errs;
    int          proto_errs;
    int          issued;
    int          retire_count;
    int          n_gpr;                             // Per instruction event counts
    int          n_csr;
    int          n_trace;
    int          n_trap;
    int          n_mret;
    logic        ack_pending;
    logic [1:0]  ack_wait;

    wb_stage_top #(.pc_reset(pc_start)) dut0 (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .instr       (instr),
        .instr_valid (instr_valid),
        .busy        (busy),
        .dmem_rsp    (dmem_rsp),
        .csr_req     (csr_req),
        .csr_rdata   (csr_rdata),
        .csr_error   (csr_fault),
        .csr_mepc    (mepc_val),
        .csr_mtvec   (mtvec_val),
        .gpr_wr      (gpr_wr),
        .cf_req      (cf_req),
        .cf_target   (cf_target),
        .cf_ack      (cf_ack),
        .exec_mret   (exec_mret),
        .trap        (trap),
        .trace       (trace)
    );

    // CSR file model, read data tagged with the address
    assign csr_rdata = {20'hc5a01, csr_req.addr};
    assign csr_fault = csr_error && csr_req.en;     // Fault only with the access

    initial begin
        g_clk = 1'b0;
        forever #20 g_clk = ~g_clk;
    end

    // Helpers --------------------
    function automatic logic [31:0] rand_word();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] want);
        checks++;
        assert (got === want) else begin
            $display("Error %0t ns: %s is %h, expected %h", $time, name, got, want);
            value_errs++;
        end
    endtask

    task automatic expect_count(input string what, input int got, input int want);
        checks++;
        assert (got == want) else begin
            $display("At %0t ns an instruction produced %0d %s instead of %0d",
                     $time, got, what, want);
            proto_errs++;
        end
    endtask

    // Loaded value by shifting the lane to the top and back down
    function automatic wb_word_t load_expect(input wb_word_t data, input logic [1:0] off,
                                             input logic [1:0] width, input logic sext);
        wb_word_t t;
        int       keep;                             // Bits kept from the lane
        if (width == lsu_word) begin
            return data;
        end
        keep = (width == lsu_byte) ? 8 : 16;
        t = data << (32 - keep - 8 * off);
        return sext ? wb_word_t'($signed(t) >>> (32 - keep)) : t >> (32 - keep);
    endfunction

    function automatic wb_instr_t make_instr(input int fu_pos, input logic [4:0] uop_bits,
                                             input logic [1:0] size);
        wb_instr_t   ins;
        logic [31:0] w;
        ins = '0;
        w = rand_word();
        ins.rd       = w[4:0];
        ins.opr_a    = rand_word();
        ins.opr_b    = rand_word();
        ins.uop.op   = uop_bits;
        ins.fu[fu_pos] = 1'b1;
        ins.size     = size;
        ins.instr    = rand_word();
        return ins;
    endfunction

    task automatic clear_expect();
        exp_wen  = 1'b0;
        exp_cf   = 1'b0;
        exp_trap = 1'b0;
        exp_mret = 1'b0;
        exp_csr  = 1'b0;
    endtask

    task automatic expect_trap(input logic [5:0] cause, input wb_word_t mtval);
        exp_cf     = 1'b1;
        exp_target = mtvec_val;                     // All traps land on mtvec
        exp_trap   = 1'b1;
        exp_cause  = cause;
        exp_mtval  = mtval;
    endtask

    task automatic expect_write(input logic [4:0] rd, input wb_word_t data);
        exp_wen   = 1'b1;
        exp_rd    = rd;
        exp_wdata = data;
    endtask

    // Present one instruction and wait for it to retire
    task automatic issue(input wb_instr_t ins);
        int start;
        start = retire_count;
        instr = ins;
        instr_valid = 1'b1;
        issued++;
        while (retire_count == start) begin
            @(posedge g_clk);
        end
        #2;
        instr_valid = 1'b0;
        instr       = '0;                           // Idle stage has no unit select
        dmem_rsp    = '0;
        csr_error   = 1'b0;
        clear_expect();
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge g_clk);
            #2;
        end
    endtask

    // Instruction kinds --------------------
    task automatic run_alu(input int fu_pos, input logic [1:0] size);
        wb_instr_t ins;
        ins = make_instr(fu_pos, 5'd0, size);
        expect_write(ins.rd, ins.opr_a);            // Result rides on operand a
        issue(ins);
    endtask

    task automatic run_load(input logic [1:0] width, input logic sext,
                            input logic [1:0] off, input logic err);
        wb_uop_u   u;
        wb_instr_t ins;
        wb_word_t  data;
        u = '0;
        u.lsu.load  = 1'b1;
        u.lsu.width = width;
        u.lsu.sext  = sext;
        ins = make_instr(fu_lsu, u.op, 2'd2);
        ins.opr_b[1:0] = off;
        data = rand_word();
        dmem_rsp.valid = 1'b1;
        dmem_rsp.error = err;
        dmem_rsp.rdata = data;
        if (err) begin
            expect_trap(trap_ldaccess, ins.opr_b);
        end else begin
            expect_write(ins.rd, load_expect(data, off, width, sext));
        end
        issue(ins);
    endtask

    task automatic run_store(input logic err);
        wb_uop_u   u;
        wb_instr_t ins;
        u = '0;
        u.lsu.store = 1'b1;
        u.lsu.width = lsu_word;
        ins = make_instr(fu_lsu, u.op, 2'd2);
        dmem_rsp.valid = 1'b1;
        dmem_rsp.error = err;
        dmem_rsp.rdata = rand_word();
        if (err) begin
            expect_trap(trap_staccess, ins.opr_b);
        end
        issue(ins);
    endtask

    task automatic run_flow(input logic [4:0] op, input wb_word_t target,
                            input logic [1:0] size);
        wb_instr_t ins;
        ins = make_instr(fu_cfu, op, size);
        ins.opr_a = target;
        case (op)
            cfu_ecall:  expect_trap(trap_ecallm, '0);
            cfu_ebreak: expect_trap(trap_breakpt, model_pc);
            cfu_mret: begin
                exp_cf     = 1'b1;
                exp_target = mepc_val;
                exp_mret   = 1'b1;
            end
            default: begin
                exp_cf     = 1'b1;
                exp_target = target;
                if (op != cfu_taken) begin
                    expect_write(ins.rd, model_pc + 2 * size);   // Link
                end
            end
        endcase
        issue(ins);
    endtask

    task automatic run_csr(input logic rd, input logic wr, input logic set,
                           input logic clr, input logic err);
        wb_uop_u   u;
        wb_instr_t ins;
        u = '0;
        u.csr.read  = rd;
        u.csr.write = wr;
        u.csr.set   = set;
        u.csr.clear = clr;
        ins = make_instr(fu_csr, u.op, 2'd2);
        csr_error = err;
        exp_csr   = 1'b1;
        if (err) begin
            expect_trap(trap_iopcode, '0);
        end else if (rd) begin
            expect_write(ins.rd, {20'hc5a01, ins.opr_b[11:0]});
        end
        issue(ins);
    endtask

    // Trap flagged by an earlier stage, cause rides in rd
    task automatic run_upstream(input logic [5:0] cause);
        wb_instr_t ins;
        ins = make_instr(fu_alu, 5'd0, 2'd2);
        ins.trap = 1'b1;
        ins.rd   = cause[4:0];
        expect_trap(cause, (cause == trap_ldalign || cause == trap_stalign) ?
                           ins.opr_b : '0);
        issue(ins);
    endtask

    // Fetch side --------------------
    always @(negedge g_clk) begin
        if (cf_req && !ack_pending && !cf_ack) begin
            ack_pending = 1'b1;
            ack_wait    = rand_word() >> 16;        // 0 to 3 extra cycles
        end
    end

    always @(posedge g_clk) begin
        #2;
        if (!g_resetn || cf_ack) begin
            cf_ack      = 1'b0;                     // One cycle completes it
            ack_pending = 1'b0;
        end else if (ack_pending) begin
            if (ack_wait == 2'd0) begin
                cf_ack      = 1'b1;
                ack_pending = 1'b0;
            end else begin
                ack_wait = ack_wait - 2'd1;
            end
        end
    end

    // Checker, mid cycle where all inputs are stable --------------------
    always @(negedge g_clk) begin
        if (!instr_valid) begin
            expect_equal("busy", busy, 1'b0);
            expect_equal("cf_req", cf_req, 1'b0);
            expect_equal("gpr_wr.en", gpr_wr.en, 1'b0);
            expect_equal("csr_req.en", csr_req.en, 1'b0);
            expect_equal("trace.valid", trace.valid, 1'b0);
            expect_equal("trap.cpu", trap.cpu, 1'b0);
            expect_equal("exec_mret", exec_mret, 1'b0);
        end else begin
            expect_equal("cf_req", cf_req, exp_cf);
            expect_equal("busy", busy, exp_cf && !cf_ack);           // Stall until ack
            if (exp_cf) begin
                expect_equal("cf_target", cf_target, exp_target);
            end
            expect_equal("trap.cpu", trap.cpu, exp_trap && cf_ack);
            expect_equal("exec_mret", exec_mret, exp_mret && !busy);
            if (gpr_wr.en) begin
                n_gpr++;
                expect_equal("gpr_wr.rd", gpr_wr.rd, exp_rd);
                expect_equal("gpr_wr.wdata", gpr_wr.wdata, exp_wdata);
            end
            if (csr_req.en) begin
                n_csr++;
                expect_equal("csr_req.addr", csr_req.addr, instr.opr_b[11:0]);
                expect_equal("csr_req.wdata", csr_req.wdata, instr.opr_a);
                expect_equal("csr_req.wr", csr_req.wr, instr.uop.csr.write);
                expect_equal("csr_req.set", csr_req.set, instr.uop.csr.set);
                expect_equal("csr_req.clr", csr_req.clr, instr.uop.csr.clear);
            end
            if (trace.valid) begin
                n_trace++;
                expect_equal("trace.pc", trace.pc, model_pc);
                expect_equal("trace.instr", trace.instr, instr.instr);
            end
            if (trap.cpu) begin
                n_trap++;
                expect_equal("trap.cause", trap.cause, exp_cause);
                expect_equal("trap.mtval", trap.mtval, exp_mtval);
                expect_equal("trap.pc", trap.pc, model_pc);
            end
            if (exec_mret) begin
                n_mret++;
            end
            if (!busy) begin                        // Retires at the next edge
                expect_count("register writes", n_gpr, exp_wen);
                expect_count("CSR requests", n_csr, exp_csr);
                expect_count("trace records", n_trace, instr.size != 2'd0);
                expect_count("trap reports", n_trap, exp_trap);
                expect_count("MRET pulses", n_mret, exp_mret);
                model_pc = exp_cf ? exp_target : model_pc + 2 * instr.size;
                n_gpr   = 0;
                n_csr   = 0;
                n_trace = 0;
                n_trap  = 0;
                n_mret  = 0;
                retire_count++;
            end
        end
    end

    // Run limit
    always @(posedge g_clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("Run stopped after %0d cycles with %0d of %0d instructions retired",
                     cycles, retire_count, issued);
            $display("Testbench failed");
            $finish;
        end
    end

    // Stimulus --------------------
    initial begin
        g_resetn    = 1'b0;
        instr       = '0;
        instr_valid = 1'b0;
        dmem_rsp    = '0;
        csr_error   = 1'b0;
        cf_ack      = 1'b0;
        ack_pending = 1'b0;
        ack_wait    = 2'd0;
        lcg_state   = 32'd75414;
        model_pc    = pc_start;
        {cycles, checks, value_errs, proto_errs, issued, retire_count} = '0;
        {n_gpr, n_csr, n_trace, n_trap, n_mret} = '0;
        clear_expect();
        repeat (8) @(posedge g_clk);
        #2;
        g_resetn = 1'b1;
        idle(2);

        run_alu(fu_alu, 2'd2);
        run_alu(fu_mul, 2'd2);
        run_alu(fu_alu, 2'd1);                      // Compressed
        run_alu(fu_alu, 2'd0);                      // No trace, PC holds
        run_alu(fu_mul, 2'd2);

        for (int off = 0; off < 4; off++) begin
            run_load(lsu_byte, 1'b0, off[1:0], 1'b0);
            run_load(lsu_byte, 1'b1, off[1:0], 1'b0);
        end
        for (int off = 0; off < 4; off += 2) begin
            run_load(lsu_half, 1'b0, off[1:0], 1'b0);
            run_load(lsu_half, 1'b1, off[1:0], 1'b0);
        end
        run_load(lsu_word, 1'b0, 2'd0, 1'b0);
        run_load(lsu_half, 1'b1, 2'd2, 1'b1);      // Bus error
        run_store(1'b0);
        run_store(1'b1);

        run_flow(cfu_jali, 32'h8000_0400, 2'd2);
        run_alu(fu_alu, 2'd2);
        run_flow(cfu_jalr, 32'h8000_0822, 2'd1);
        run_flow(cfu_taken, 32'h8000_0040, 2'd2);
        idle(3);
        run_flow(cfu_ecall, '0, 2'd2);
        run_flow(cfu_ebreak, '0, 2'd1);
        run_flow(cfu_mret, '0, 2'd2);

        run_csr(1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
        run_csr(1'b1, 1'b0, 1'b1, 1'b0, 1'b0);
        run_csr(1'b0, 1'b0, 1'b0, 1'b1, 1'b0);     // Write only, no result
        run_csr(1'b1, 1'b1, 1'b0, 1'b0, 1'b1);     // Rejected access
        run_upstream(trap_ldalign);
        run_upstream(6'd1);
        run_alu(fu_alu, 2'd2);
        idle(4);

        if (retire_count != issued) begin
            $display("Only %0d of %0d instructions retired", retire_count, issued);
            proto_errs++;
        end
        $display("Checks %0d, value errors %0d, protocol errors %0d",
                 checks, value_errs, proto_errs);
        if (value_errs == 0 && proto_errs == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/wb_stage_top.sv
/*
 * Writeback stage of the core.
 * Joins the load, CSR, control flow and register commit units.
 * pc_reset sets the program counter value after reset.
 */
`timescale 1ns/1ps
`default_nettype none

module wb_stage_top import wb_pkg::*; #(
    parameter wb_word_t pc_reset = 32'h8000_0000
) (
    input  logic         g_clk,
    input  logic         g_resetn,
    input  wb_instr_t    instr,         // From the previous stage
    input  logic         instr_valid,
    output logic         busy,
    input  wb_dmem_rsp_t dmem_rsp,
    output wb_csr_req_t  csr_req,       // CSR file port
    input  wb_word_t     csr_rdata,
    input  logic         csr_error,
    input  wb_word_t     csr_mepc,
    input  wb_word_t     csr_mtvec,
    output wb_gpr_wr_t   gpr_wr,        // Register file port
    output logic         cf_req,        // Fetch redirect
    output wb_word_t     cf_target,
    input  logic         cf_ack,
    output logic         exec_mret,
    output wb_trap_t     trap,
    output wb_trace_t    trace
);

    logic       progress;
    wb_word_t   link_pc;
    logic       link_wen;
    wb_word_t   lsu_rdata;
    logic       lsu_wen;
    logic       lsu_trap;
    logic [5:0] lsu_cause;
    logic       csr_wen;
    wb_word_t   csr_value;
    logic       csr_trap;

    // Units --------------------
    wb_load_unit u_load (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .instr     (instr),
        .progress  (progress),
        .dmem_rsp  (dmem_rsp),
        .lsu_rdata (lsu_rdata),
        .lsu_wen   (lsu_wen),
        .lsu_trap  (lsu_trap),
        .lsu_cause (lsu_cause)
    );

    wb_csr_access u_csr (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .instr     (instr),
        .progress  (progress),
        .csr_req   (csr_req),
        .csr_rdata (csr_rdata),
        .csr_error (csr_error),
        .csr_wen   (csr_wen),
        .csr_value (csr_value),
        .csr_trap  (csr_trap)
    );

    wb_flow_ctrl #(.pc_reset(pc_reset)) u_flow (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .instr       (instr),
        .instr_valid (instr_valid),
        .busy        (busy),
        .progress    (progress),
        .link_pc     (link_pc),
        .link_wen    (link_wen),
        .lsu_trap    (lsu_trap),
        .lsu_cause   (lsu_cause),
        .csr_trap    (csr_trap),
        .csr_mepc    (csr_mepc),
        .csr_mtvec   (csr_mtvec),
        .cf_req      (cf_req),
        .cf_target   (cf_target),
        .cf_ack      (cf_ack),
        .exec_mret   (exec_mret),
        .trap        (trap),
        .trace       (trace)
    );

    // Drains all unit results into the register file
    wb_gpr_commit u_commit (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .instr     (instr),
        .progress  (progress),
        .lsu_wen   (lsu_wen),
        .lsu_rdata (lsu_rdata),
        .csr_wen   (csr_wen),
        .csr_value (csr_value),
        .link_wen  (link_wen),
        .link_pc   (link_pc),
        .gpr_wr    (gpr_wr)
    );

endmodule

`default_nettype wire

//--- hdl/wb_gpr_commit.sv
/*
 * Register file write port of the writeback stage.
 * Picks the result of the unit that owns the instruction and makes
 * at most one write per instruction, however long the stage stalls.
 */
`timescale 1ns/1ps
`default_nettype none

module wb_gpr_commit import wb_pkg::*; (
    input  logic       g_clk,
    input  logic       g_resetn,
    input  wb_instr_t  instr,
    input  logic       progress,
    input  logic       lsu_wen,      // Load result
    input  wb_word_t   lsu_rdata,
    input  logic       csr_wen,      // CSR read value
    input  wb_word_t   csr_value,
    input  logic       link_wen,     // Return address of a jump
    input  wb_word_t   link_pc,
    output wb_gpr_wr_t gpr_wr
);

    logic alu_wen;
    logic any_wen;
    logic written_q;                 // Write already made, still stalled

    // ALU and multiplier results arrive on operand a
    assign alu_wen = instr.fu[fu_alu] || instr.fu[fu_mul];
    assign any_wen = alu_wen || lsu_wen || csr_wen || link_wen;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            written_q <= 1'b0;
        end else if (progress) begin
            written_q <= 1'b0;
        end else if (gpr_wr.en) begin
            written_q <= 1'b1;
        end
    end

    // Upstream trap means rd holds a cause, not a register
    assign gpr_wr.en = any_wen && !instr.trap && !written_q;
    assign gpr_wr.rd = instr.rd;

    // Unit enables are exclusive, so an and-or mux is enough
    assign gpr_wr.wdata = {xlen{alu_wen}}  & instr.opr_a |
                          {xlen{lsu_wen}}  & lsu_rdata   |
                          {xlen{csr_wen}}  & csr_value   |
                          {xlen{link_wen}} & link_pc;

endmodule

`default_nettype wire

//--- hdl/wb_flow_ctrl.sv
/*
 * Program counter and control flow of the writeback stage.
 * Raises a level request to fetch for jumps, MRET and traps and stalls
 * the stage until it is acknowledged. Also reports traps and emits
 * one trace record per retired instruction.
 */
`timescale 1ns/1ps
`default_nettype none

module wb_flow_ctrl import wb_pkg::*; #(
    parameter wb_word_t pc_reset = 32'h8000_0000   // PC after reset
) (
    input  logic       g_clk,
    input  logic       g_resetn,
    input  wb_instr_t  instr,
    input  logic       instr_valid,
    output logic       busy,         // Back-pressure to previous stage
    output logic       progress,     // Instruction retires
    output wb_word_t   link_pc,      // Next sequential PC
    output logic       link_wen,     // JAL/JALR link write
    input  logic       lsu_trap,
    input  logic [5:0] lsu_cause,
    input  logic       csr_trap,
    input  wb_word_t   csr_mepc,
    input  wb_word_t   csr_mtvec,
    output logic       cf_req,       // Level request to fetch
    output wb_word_t   cf_target,
    input  logic       cf_ack,
    output logic       exec_mret,    // Pulse on MRET retirement
    output wb_trap_t   trap,
    output wb_trace_t  trace
);

    wb_word_t pc_q;
    logic     is_cfu;
    logic     is_taken;              // Branch or jump
    logic     is_ecall;
    logic     is_ebreak;
    logic     is_mret;
    logic     any_trap;
    logic     need_cf;               // Instruction needs a flow change
    logic     cf_fin;                // Request completes this cycle
    logic     addr_align;

    // Decode --------------------
    assign is_cfu    = instr.fu[fu_cfu];
    assign is_taken  = is_cfu && (instr.uop.op == cfu_taken ||
                                  instr.uop.op == cfu_jali  ||
                                  instr.uop.op == cfu_jalr);
    assign is_ecall  = is_cfu && instr.uop.op == cfu_ecall;
    assign is_ebreak = is_cfu && instr.uop.op == cfu_ebreak;
    assign is_mret   = is_cfu && instr.uop.op == cfu_mret;
    assign link_wen  = is_cfu && (instr.uop.op == cfu_jali ||
                                  instr.uop.op == cfu_jalr);

    // Every trap source lands on mtvec
    assign any_trap = is_ecall || is_ebreak || instr.trap || lsu_trap || csr_trap;

    // Handshakes --------------------
    assign need_cf  = instr_valid && (is_taken || is_mret || any_trap);
    assign cf_req   = need_cf;
    assign cf_fin   = cf_req && cf_ack;
    assign busy     = need_cf && !cf_fin;     // Stall until ack
    assign progress = instr_valid && !busy;

    assign cf_target = any_trap ? csr_mtvec :
                       is_mret  ? csr_mepc  :
                                  instr.opr_a;

    assign exec_mret = is_mret && progress;

    // Program counter --------------------
    assign link_pc = pc_q + {29'b0, instr.size, 1'b0};   // Size is in halfwords

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            pc_q <= pc_reset;
        end else if (cf_fin) begin
            pc_q <= cf_target;       // Redirect wins over the step
        end else if (progress) begin
            pc_q <= link_pc;
        end
    end

    // Trap report --------------------
    // Upstream alignment faults carry the address in operand b
    assign addr_align = instr.trap && ({1'b0, instr.rd} == trap_ldalign ||
                                       {1'b0, instr.rd} == trap_stalign);

    assign trap.cpu   = any_trap && cf_fin;      // Once, as the redirect lands
    assign trap.cause = lsu_trap  ? lsu_cause    :
                        is_ebreak ? trap_breakpt :
                        is_ecall  ? trap_ecallm  :
                        csr_trap  ? trap_iopcode :
                                    {1'b0, instr.rd};
    assign trap.mtval = is_ebreak               ? pc_q        :
                        (lsu_trap || addr_align) ? instr.opr_b :
                                                  '0;
    assign trap.pc    = pc_q;

    // Trace --------------------
    assign trace.valid = |instr.size && progress;
    assign trace.pc    = pc_q;
    assign trace.instr = instr.instr;

endmodule

`default_nettype wire

//--- hdl/wb_csr_access.sv
/*
 * CSR access port of the writeback stage.
 * Makes one request per CSR instruction and hands back the read value.
 * An access the CSR file rejects turns into an illegal opcode trap.
 */
`timescale 1ns/1ps
`default_nettype none

module wb_csr_access import wb_pkg::*; (
    input  logic        g_clk,
    input  logic        g_resetn,
    input  wb_instr_t   instr,
    input  logic        progress,
    output wb_csr_req_t csr_req,      // To the CSR file
    input  wb_word_t    csr_rdata,    // Same cycle read data
    input  logic        csr_error,    // Same cycle access fault
    output logic        csr_wen,      // Read value goes to the GPR
    output wb_word_t    csr_value,
    output logic        csr_trap
);

    logic is_csr;
    logic done_q;                     // Access made, stage still stalled
    logic err_q;                      // Fault of that access

    assign is_csr = instr.fu[fu_csr];

    always_ff @(posedge g_clk) begin
        if (!g_resetn || progress) begin
            done_q <= 1'b0;
            err_q  <= 1'b0;
        end else if (csr_req.en) begin
            done_q <= 1'b1;
            err_q  <= csr_error;      // Kept while the trap is pending
        end
    end

    // Request --------------------
    assign csr_req.en    = is_csr && !done_q;   // First cycle only
    assign csr_req.wr    = is_csr && instr.uop.csr.write;
    assign csr_req.set   = is_csr && instr.uop.csr.set;
    assign csr_req.clr   = is_csr && instr.uop.csr.clear;
    assign csr_req.addr  = instr.opr_b[11:0];
    assign csr_req.wdata = instr.opr_a;

    // Result --------------------
    assign csr_wen   = is_csr && instr.uop.csr.read && !done_q && !csr_error;
    assign csr_value = csr_rdata;
    assign csr_trap  = is_csr && (done_q ? err_q : csr_error);

endmodule

`default_nettype wire

//--- hdl/wb_load_unit.sv
/*
 * Load data path of the writeback stage.
 * Picks the addressed byte or half out of the read word and extends it,
 * and keeps a bus error visible until the instruction retires.
 */
`timescale 1ns/1ps
`default_nettype none

module wb_load_unit import wb_pkg::*; (
    input  logic         g_clk,
    input  logic         g_resetn,
    input  wb_instr_t    instr,        // Instruction in the stage
    input  logic         progress,     // Instruction retires this cycle
    input  wb_dmem_rsp_t dmem_rsp,     // Memory response
    output wb_word_t     lsu_rdata,    // Aligned, extended load data
    output logic         lsu_wen,      // Load result to be written
    output logic         lsu_trap,     // Bus error on this access
    output logic [5:0]   lsu_cause
);

    logic       is_lsu;
    logic       rsp_err;
    logic       err_q;                 // Error seen, waiting for retire
    logic [1:0] addr_lo;
    logic [7:0] byte_sel;
    logic [15:0] half_sel;

    assign is_lsu  = instr.fu[fu_lsu];
    assign addr_lo = instr.opr_b[1:0];  // Byte offset within the word
    assign rsp_err = dmem_rsp.valid && dmem_rsp.error;

    // Bus error hold --------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            err_q <= 1'b0;
        end else if (progress) begin
            err_q <= 1'b0;             // Next instruction starts clean
        end else if (rsp_err) begin
            err_q <= 1'b1;
        end
    end

    assign lsu_trap  = is_lsu && (rsp_err || err_q);
    assign lsu_cause = instr.uop.lsu.store ? trap_staccess : trap_ldaccess;

    // No write if the access faulted
    assign lsu_wen = is_lsu && instr.uop.lsu.load && !lsu_trap;

    // Alignment --------------------
    always_comb begin
        case (addr_lo)
            2'b00:   byte_sel = dmem_rsp.rdata[7:0];
            2'b01:   byte_sel = dmem_rsp.rdata[15:8];
            2'b10:   byte_sel = dmem_rsp.rdata[23:16];
            default: byte_sel = dmem_rsp.rdata[31:24];
        endcase
        half_sel = addr_lo[1] ? dmem_rsp.rdata[31:16] : dmem_rsp.rdata[15:0];

        // Fill the top with the sign bit or zeros
        case (instr.uop.lsu.width)
            lsu_byte: lsu_rdata = {{24{instr.uop.lsu.sext & byte_sel[7]}}, byte_sel};
            lsu_half: lsu_rdata = {{16{instr.uop.lsu.sext & half_sel[15]}}, half_sel};
            lsu_word: lsu_rdata = dmem_rsp.rdata;
            default:  lsu_rdata = '0;  // Undefined width code
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/wb_pkg.sv
/*
 * Shared types and constants for the writeback stage.
 * Every stage module pulls these in by a wildcard import in its header.
 * Holds the unit positions, the micro-op union, the port structs
 * and the RISC-V trap cause codes.
 */
`default_nettype none

package wb_pkg;

    parameter int xlen = 32;                    // Data path width

    typedef logic [xlen-1:0] wb_word_t;

    // Functional unit positions --------------------
    parameter int fu_alu = 0;
    parameter int fu_mul = 1;
    parameter int fu_lsu = 2;
    parameter int fu_cfu = 3;
    parameter int fu_csr = 4;

    typedef logic [4:0] wb_fu_t;                // One-hot unit select

    // Micro-op views --------------------
    parameter logic [1:0] lsu_byte = 2'b01;     // Load/store width codes
    parameter logic [1:0] lsu_half = 2'b10;
    parameter logic [1:0] lsu_word = 2'b11;

    typedef struct packed {
        logic       load;
        logic       store;
        logic [1:0] width;                      // One of the lsu_* codes
        logic       sext;                       // Sign extend load data
    } wb_lsu_uop_t;

    typedef struct packed {
        logic pad;                              // Unused
        logic read;
        logic write;
        logic set;
        logic clear;
    } wb_csr_uop_t;

    // Same 5 bits, meaning depends on the unit field
    typedef union packed {
        wb_lsu_uop_t lsu;
        wb_csr_uop_t csr;
        logic [4:0]  op;                        // Control flow op code
    } wb_uop_u;

    parameter logic [4:0] cfu_taken  = 5'd1;    // Taken conditional branch
    parameter logic [4:0] cfu_jali   = 5'd2;
    parameter logic [4:0] cfu_jalr   = 5'd3;
    parameter logic [4:0] cfu_ecall  = 5'd4;
    parameter logic [4:0] cfu_ebreak = 5'd5;
    parameter logic [4:0] cfu_mret   = 5'd6;

    // Port structs --------------------
    typedef struct packed {
        logic [4:0] rd;                         // Trap cause if trap is set
        wb_word_t   opr_a;
        wb_word_t   opr_b;
        wb_uop_u    uop;
        wb_fu_t     fu;
        logic       trap;                       // Trap raised upstream
        logic [1:0] size;                       // In halfwords
        logic [31:0] instr;
    } wb_instr_t;

    typedef struct packed {
        logic     valid;
        logic     error;
        wb_word_t rdata;
    } wb_dmem_rsp_t;

    typedef struct packed {
        logic        en;
        logic        wr;
        logic        set;
        logic        clr;
        logic [11:0] addr;
        wb_word_t    wdata;
    } wb_csr_req_t;

    typedef struct packed {
        logic       en;
        logic [4:0] rd;
        wb_word_t   wdata;
    } wb_gpr_wr_t;

    typedef struct packed {
        logic       cpu;
        logic [5:0] cause;
        wb_word_t   mtval;
        wb_word_t   pc;
    } wb_trap_t;

    typedef struct packed {
        logic        valid;
        wb_word_t    pc;
        logic [31:0] instr;
    } wb_trace_t;

    // Trap causes, standard machine mode encodings
    parameter logic [5:0] trap_iopcode  = 6'd2;
    parameter logic [5:0] trap_breakpt  = 6'd3;
    parameter logic [5:0] trap_ldalign  = 6'd4;
    parameter logic [5:0] trap_ldaccess = 6'd5;
    parameter logic [5:0] trap_stalign  = 6'd6;
    parameter logic [5:0] trap_staccess = 6'd7;
    parameter logic [5:0] trap_ecallm   = 6'd11;

endpackage

`default_nettype wire
